/* verilog/ft64DataPkg.sv */
package ft64DataPkg;

    // ============================================================
    // Datapath widths
    // ============================================================

    parameter int DataWidth = 64;

    typedef logic [63:0]  word_t;    // Operand or result
    typedef logic [127:0] dword_t;   // Full product

    // Lane size as encoded in the instruction size field
    typedef enum logic [1:0]
    {
        lane8  = 2'd0,
        lane16 = 2'd1,
        lane32 = 2'd2,
        lane64 = 2'd3
    } laneSize_t;

    // Per-lane arithmetic selected in the lane unit
    typedef enum logic [1:0]
    {
        kindAdd = 2'd0,
        kindSub = 2'd1,
        kindMin = 2'd2,
        kindMax = 2'd3
    } arithKind_t;

endpackage

/* verilog/ft64IsaPkg.sv */
package ft64IsaPkg;

    import ft64DataPkg::*;

    // ============================================================
    // Operations and instruction fields
    // ============================================================

    typedef enum logic [4:0]
    {
        opAdd, opSub, opMin, opMax,
        opCmp, opCmpu, opSet, opSetu,
        opAnd, opOr, opXor, opNand, opNor, opXnor, opMaj,
        opCmovEq, opCmovNe,
        opMul, opMulu, opDiv, opDivu
    } aluOp_t;

    // Same codes as the compare sub-field of the core
    typedef enum logic [2:0]
    {
        condEq = 3'd2,
        condNe = 3'd3,
        condLt = 3'd4,
        condGe = 3'd5,
        condLe = 3'd6,
        condGt = 3'd7
    } cond_t;

    typedef struct packed
    {
        aluOp_t    op;
        laneSize_t size;
        cond_t     cond;
        logic      hiSel;   // High product half, or remainder
        logic      trap;    // Overflow trap on add/sub
    } aluInstr_t;

    typedef struct packed
    {
        logic div;
        logic mul;
        logic sub;
        logic add;   // Bit 0
    } faultEnable_t;

    typedef enum logic [8:0]
    {
        faultNone     = 9'd0,
        faultOverflow = 9'd32,
        faultDivZero  = 9'd33
    } fault_t;

endpackage

/* verilog/laneArith.sv */
`timescale 1ns/1ps

module laneArith
    import ft64DataPkg::*;
#(
    parameter int DBW = DataWidth
)
(
    input  word_t      a,
    input  word_t      b,
    input  laneSize_t  size,
    input  arithKind_t kind,
    output word_t      res
);

// One full-word result per lane size
wire [DBW-1:0] sized [0:3];

for (genvar s = 0; s < 4; s++)
begin : gSize
    localparam int LW = 8 << s;   // Lane width in bits

    for (genvar l = 0; l < DBW / LW; l++)
    begin : gLane
        logic [LW-1:0] la;
        logic [LW-1:0] lb;
        logic [LW-1:0] lr;
        logic lt;

        assign la = a[l*LW +: LW];
        assign lb = b[l*LW +: LW];
        assign lt = $signed(la) < $signed(lb);

        // No carry leaves the lane
        always_comb
        begin
            case (kind)
                kindAdd: lr = la + lb;
                kindSub: lr = la - lb;
                kindMin: lr = lt ? la : lb;
                default: lr = lt ? lb : la;   // Max
            endcase
        end

        assign sized[s][l*LW +: LW] = lr;
    end
end

always_comb
begin
    case (size)
        lane8:   res = sized[0];
        lane16:  res = sized[1];
        lane32:  res = sized[2];
        default: res = sized[3];
    endcase
end

endmodule

/* verilog/compareUnit.sv */
`timescale 1ns/1ps

module compareUnit
    import ft64DataPkg::*, ft64IsaPkg::*;
#(
    parameter int DBW = DataWidth
)
(
    input  word_t     a,
    input  word_t     b,
    input  laneSize_t size,
    input  logic      signedOp,
    input  logic      threeWay,
    input  cond_t     cond,
    output word_t     res
);

logic signed [DBW:0] ea;
logic signed [DBW:0] eb;
logic lt;
logic eq;
logic hit;

// Low lane widened by one bit, so one signed compare serves both kinds
function automatic logic signed [DBW:0] extLane(word_t x, laneSize_t sz, logic sgn);
    logic signed [DBW:0] r;
    case (sz)
        lane8:   r = {{(DBW-7){sgn & x[7]}}, x[7:0]};
        lane16:  r = {{(DBW-15){sgn & x[15]}}, x[15:0]};
        lane32:  r = {{(DBW-31){sgn & x[31]}}, x[31:0]};
        default: r = {sgn & x[DBW-1], x[DBW-1:0]};
    endcase
    return r;
endfunction

assign ea = extLane(a, size, signedOp);
assign eb = extLane(b, size, signedOp);
assign lt = ea < eb;
assign eq = ea == eb;

always_comb
begin
    case (cond)
        condEq:  hit = eq;
        condNe:  hit = !eq;
        condLt:  hit = lt;
        condGe:  hit = !lt;
        condLe:  hit = lt || eq;
        condGt:  hit = !(lt || eq);
        default: hit = 1'b0;
    endcase
end

assign res = threeWay ? (lt ? '1 : eq ? '0 : word_t'(1)) : word_t'(hit);

endmodule

/* verilog/seqMultiplier.sv */
`timescale 1ns/1ps

module seqMultiplier
    import ft64DataPkg::*;
#(
    parameter int DBW = DataWidth
)
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   abort,
    input  logic   signedOp,
    input  word_t  a,
    input  word_t  b,
    output dword_t prod,
    output logic   done,
    output logic   idle
);

localparam int CntW = $clog2(DBW);

typedef enum logic {mulIdle, mulRun} mulState_t;

mulState_t state;
logic [CntW-1:0] cnt;       // Steps still to run
logic [DBW-1:0] mcand;
logic [2*DBW-1:0] acc;      // Partial product over the multiplier
logic negRes;
logic [DBW-1:0] aMag;
logic [DBW-1:0] bMag;

function automatic logic [DBW-1:0] magnitude(logic [DBW-1:0] x, logic sgn);
    return (sgn && x[DBW-1]) ? -x : x;
endfunction

// One add-and-shift step, consuming the low multiplier bit
function automatic logic [2*DBW-1:0] addShift(logic [2*DBW-1:0] p, logic [DBW-1:0] m);
    logic [DBW:0] sum;
    sum = {1'b0, p[2*DBW-1:DBW]} + (p[0] ? {1'b0, m} : '0);
    return {sum, p[DBW-1:1]};
endfunction

assign aMag = magnitude(a, signedOp);
assign bMag = magnitude(b, signedOp);

// The first step happens on the start edge
always_ff @(posedge clk)
begin
    if (rst)
    begin
        state <= mulIdle;
        cnt <= '0;
        acc <= '0;
        negRes <= 1'b0;
    end
    else if (abort && state == mulRun)
        state <= mulIdle;
    else if (start)
    begin
        mcand <= aMag;
        acc <= addShift({{DBW{1'b0}}, bMag}, aMag);
        negRes <= signedOp & (a[DBW-1] ^ b[DBW-1]);
        cnt <= CntW'(DBW - 1);
        state <= mulRun;
    end
    else if (state == mulRun)
    begin
        acc <= addShift(acc, mcand);
        cnt <= cnt - 1'b1;
        if (cnt == CntW'(1))
            state <= mulIdle;   // Last step
    end
end

assign prod = negRes ? dword_t'(-acc) : dword_t'(acc);
assign done = state == mulIdle;
assign idle = state == mulIdle;

endmodule

/* verilog/seqDivider.sv */
`timescale 1ns/1ps

module seqDivider
    import ft64DataPkg::*;
#(
    parameter int DBW = DataWidth
)
(
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    input  logic  abort,
    input  logic  signedOp,
    input  word_t a,
    input  word_t b,
    output word_t quot,
    output word_t rem,
    output logic  divZero,
    output logic  done,
    output logic  idle
);

localparam int CntW = $clog2(DBW);

typedef enum logic {divIdle, divRun} divState_t;

divState_t state;
logic [CntW-1:0] cnt;
logic [DBW-1:0] divisor;
logic [DBW-1:0] q;          // Dividend shifting out, quotient shifting in
logic [DBW-1:0] r;
logic negQ;
logic negR;
logic dz;
logic [DBW-1:0] aMag;
logic [DBW-1:0] bMag;

function automatic logic [DBW-1:0] magnitude(logic [DBW-1:0] x, logic sgn);
    return (sgn && x[DBW-1]) ? -x : x;
endfunction

// Restoring step, returns {remainder, quotient}
function automatic logic [2*DBW-1:0] divStep(logic [DBW-1:0] rIn, logic [DBW-1:0] qIn,
                                             logic [DBW-1:0] d);
    logic [DBW:0] rShift;
    logic ge;
    rShift = {rIn, qIn[DBW-1]};
    ge = rShift >= {1'b0, d};
    return {ge ? rShift[DBW-1:0] - d : rShift[DBW-1:0], qIn[DBW-2:0], ge};
endfunction

assign aMag = magnitude(a, signedOp);
assign bMag = magnitude(b, signedOp);

always_ff @(posedge clk)
begin
    if (rst)
    begin
        state <= divIdle;
        cnt <= '0;
        q <= '0;
        r <= '0;
        negQ <= 1'b0;
        negR <= 1'b0;
        dz <= 1'b0;
    end
    else if (abort && state == divRun)
    begin
        state <= divIdle;
        dz <= 1'b0;
    end
    else if (start)
    begin
        divisor <= bMag;
        {r, q} <= divStep('0, aMag, bMag);
        negQ <= signedOp & (a[DBW-1] ^ b[DBW-1]);
        negR <= signedOp & a[DBW-1];   // Remainder follows the dividend
        dz <= b == '0;
        cnt <= CntW'(DBW - 1);
        state <= divRun;
    end
    else if (state == divRun)
    begin
        {r, q} <= divStep(r, q, divisor);
        cnt <= cnt - 1'b1;
        if (cnt == CntW'(1))
            state <= divIdle;
    end
end

// With a zero divisor r ends up holding |a|, so rem comes back as a
assign quot = dz ? '1 : (negQ ? -q : q);
assign rem = negR ? -r : r;
assign divZero = dz;
assign done = state == divIdle;
assign idle = state == divIdle;

endmodule

/* verilog/faultDetect.sv */
`timescale 1ns/1ps

module faultDetect
    import ft64DataPkg::*, ft64IsaPkg::*;
#(
    parameter int DBW = DataWidth
)
(
    input  aluInstr_t    instr,
    input  word_t        a,
    input  word_t        b,
    input  word_t        o,
    input  dword_t       prod,
    input  logic         divZero,
    input  faultEnable_t excen,
    output fault_t       exc
);

logic addOvf;
logic subOvf;
logic [DBW-1:0] prodLo;
logic [DBW-1:0] prodHi;

// Sign of the result differs from what the operands allow
assign addOvf = ~(a[DBW-1] ^ b[DBW-1]) & (a[DBW-1] ^ o[DBW-1]);
assign subOvf = (a[DBW-1] ^ b[DBW-1]) & (a[DBW-1] ^ o[DBW-1]);

assign prodLo = prod[DBW-1:0];
assign prodHi = prod[2*DBW-1:DBW];

always_comb
begin
    exc = faultNone;
    case (instr.op)
        opAdd:   if (instr.trap && excen.add && addOvf) exc = faultOverflow;
        opSub:   if (instr.trap && excen.sub && subOvf) exc = faultOverflow;
        opMul:   if (excen.mul && prodHi != {DBW{prodLo[DBW-1]}}) exc = faultOverflow;
        opMulu:  if (excen.mul && prodHi != '0) exc = faultOverflow;
        opDiv, opDivu:
                 if (excen.div && divZero) exc = faultDivZero;
        default: exc = faultNone;
    endcase
end

endmodule

/* verilog/ft64Alu.sv */
`timescale 1ns/1ps

module ft64Alu
    import ft64DataPkg::*, ft64IsaPkg::*;
#(
    parameter int DBW = DataWidth
)
(
    input  logic         clk,
    input  logic         rst,
    input  logic         ld,
    input  logic         abort,
    input  aluInstr_t    instr,
    input  word_t        a,
    input  word_t        b,
    input  word_t        c,
    input  faultEnable_t excen,
    output word_t        o,
    output logic         done,
    output logic         idle,
    output fault_t       exc
);

logic isMul;
logic isDiv;
logic mulSigned;
logic divSigned;
logic cmpSigned;
logic threeWay;
arithKind_t arithKind;
word_t arithRes;
word_t cmpRes;
word_t quot;
word_t rem;
dword_t prod;
logic divZero;
logic mulDone, mulIdle, divDone, divIdle;

// ============================================================
// Decode
// ============================================================

assign isMul = instr.op inside {opMul, opMulu};
assign isDiv = instr.op inside {opDiv, opDivu};
assign mulSigned = instr.op == opMul;
assign divSigned = instr.op == opDiv;
assign cmpSigned = instr.op inside {opCmp, opSet};
assign threeWay = instr.op inside {opCmp, opCmpu};

always_comb
begin
    case (instr.op)
        opSub:   arithKind = kindSub;
        opMin:   arithKind = kindMin;
        opMax:   arithKind = kindMax;
        default: arithKind = kindAdd;
    endcase
end

laneArith #(.DBW(DBW)) uArith
(
    .a(a),
    .b(b),
    .size(instr.size),
    .kind(arithKind),
    .res(arithRes)
);

compareUnit #(.DBW(DBW)) uCmp
(
    .a(a),
    .b(b),
    .size(instr.size),
    .signedOp(cmpSigned),
    .threeWay(threeWay),
    .cond(instr.cond),
    .res(cmpRes)
);

seqMultiplier #(.DBW(DBW)) uMul
(
    .clk(clk),
    .rst(rst),
    .start(ld && isMul),
    .abort(abort),
    .signedOp(mulSigned),
    .a(a),
    .b(b),
    .prod(prod),
    .done(mulDone),
    .idle(mulIdle)
);

seqDivider #(.DBW(DBW)) uDiv
(
    .clk(clk),
    .rst(rst),
    .start(ld && isDiv),
    .abort(abort),
    .signedOp(divSigned),
    .a(a),
    .b(b),
    .quot(quot),
    .rem(rem),
    .divZero(divZero),
    .done(divDone),
    .idle(divIdle)
);

// ============================================================
// Result select
// ============================================================

always_comb
begin
    case (instr.op)
        opAdd, opSub, opMin, opMax:     o = arithRes;
        opCmp, opCmpu, opSet, opSetu:   o = cmpRes;
        opAnd:    o = a & b;
        opOr:     o = a | b;
        opXor:    o = a ^ b;
        opNand:   o = ~(a & b);
        opNor:    o = ~(a | b);
        opXnor:   o = ~(a ^ b);
        opMaj:    o = (a & b) | (a & c) | (b & c);
        opCmovEq: o = (a == '0) ? b : c;
        opCmovNe: o = (a != '0) ? b : c;
        opMul, opMulu: o = instr.hiSel ? prod[2*DBW-1:DBW] : prod[DBW-1:0];
        opDiv, opDivu: o = instr.hiSel ? rem : quot;
        default:  o = 64'hDEADDEADDEADDEAD;   // Unused encodings
    endcase
end

// Single-cycle ops are always finished
assign done = isMul ? mulDone : isDiv ? divDone : 1'b1;
assign idle = isMul ? mulIdle : isDiv ? divIdle : 1'b1;

faultDetect #(.DBW(DBW)) uFault
(
    .instr(instr),
    .a(a),
    .b(b),
    .o(o),
    .prod(prod),
    .divZero(divZero),
    .excen(excen),
    .exc(exc)
);

endmodule

/* testbench/ft64Alu_checker.sv */
`timescale 1ns/1ps

module ft64AluChecker
    import ft64IsaPkg::*;
#(
    parameter int DBW = 64
)
(
    input logic         clk,
    input logic         rst,
    input logic         ld,
    input logic         abort,
    input logic         done,
    input logic         mulIdle,
    input logic         divIdle,
    input faultEnable_t excen,
    input fault_t       exc
);

localparam int CntW = $clog2(DBW) + 1;

logic [CntW-1:0] sinceLoad;   // Cycles since the last ld, saturating

always_ff @(posedge clk)
begin
    if (rst || ld)
        sinceLoad <= '0;
    else if (sinceLoad != '1)
        sinceLoad <= sinceLoad + 1'b1;
end

// ============================================================
// Handshake and fault properties
// ============================================================

// No unit stays busy longer than DBW cycles after its start
doneWhenIdle: assert property (@(posedge clk) disable iff (rst)
    (sinceLoad >= CntW'(DBW - 1)) |-> done)
    else $error("done low while neither unit is busy");

noFaultDisabled: assert property (@(posedge clk) disable iff (rst)
    (excen == '0) |-> (exc == faultNone))
    else $error("fault reported with all enables clear");

// Abort without a new load empties both units
abortIdles: assert property (@(posedge clk) disable iff (rst)
    (abort && !ld) |=> (mulIdle && divIdle))
    else $error("unit still busy after abort");

endmodule

bind ft64Alu ft64AluChecker #(.DBW(DBW)) uChecker
(
    .clk(clk),
    .rst(rst),
    .ld(ld),
    .abort(abort),
    .done(done),
    .mulIdle(mulIdle),
    .divIdle(divIdle),
    .excen(excen),
    .exc(exc)
);

/* testbench/ft64AluTb.sv */
`timescale 1ns/1ps

module ft64AluTb
    import ft64DataPkg::*, ft64IsaPkg::*;
();

localparam int DBW = DataWidth;
localparam int NumRandom = 24;
localparam string VecFile = "testbench/ft64Alu_vectors.txt";

// One line of the vector file
typedef struct packed
{
    aluInstr_t    instr;
    word_t        a;
    word_t        b;
    word_t        c;
    faultEnable_t excen;
    word_t        expO;
    fault_t       expExc;
} vector_t;

logic         clk;
logic         rst;
logic         ld;
logic         abort;
aluInstr_t    instr;
word_t        a;
word_t        b;
word_t        c;
faultEnable_t excen;
word_t        o;
logic         done;
logic         idle;
fault_t       exc;

vector_t vectors[$];
logic [31:0] lcgState = 32'd14197;
logic fileOk;
int cycles = 0;
int cycleLimit = 0;     // Zero until the vectors are counted
int checks;
int wordErrors;
int faultErrors;
int levelErrors;
int otherErrors;

ft64Alu #(.DBW(DBW)) DUT
(
    .clk(clk),
    .rst(rst),
    .ld(ld),
    .abort(abort),
    .instr(instr),
    .a(a),
    .b(b),
    .c(c),
    .excen(excen),
    .o(o),
    .done(done),
    .idle(idle),
    .exc(exc)
);

always #5 clk = ~clk;

always @(posedge clk)
begin
    cycles <= cycles + 1;
    if (cycleLimit > 0 && cycles >= cycleLimit)
    begin
        $display("Timeout after %0d cycles, the DUT never raised done", cycles);
        $display("Test failed");
        $finish;
    end
end

// ============================================================
// Checks and helpers
// ============================================================

task automatic checkWord(input string name, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected)
    begin
        wordErrors++;
        $display("error %s: expected %h, actual %h", name, expected, actual);
    end
endtask

task automatic checkFault(input string name, input fault_t expected, input fault_t actual);
    checks++;
    if (actual !== expected)
    begin
        faultErrors++;
        $display("error %s: expected %0d, actual %0d", name, expected, actual);
    end
endtask

task automatic checkLevel(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected)
    begin
        levelErrors++;
        $display("error %s: expected %b, actual %b", name, expected, actual);
    end
endtask

function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
endfunction

function automatic word_t randWord();
    word_t w;
    w[63:32] = lcgNext();
    w[31:0] = lcgNext();
    return w;
endfunction

task automatic loadVectors();
    int fd;
    int n;
    string line;
    logic [31:0] fOp, fSize, fCond, fHi, fTrap, fExcen, fExc;
    word_t fa, fb, fc, fo;
    vector_t v;
    fd = $fopen(VecFile, "r");
    fileOk = fd != 0;
    if (fileOk)
    begin
        while ($fgets(line, fd) > 0)
        begin
            if (line.len() > 2 && line.getc(0) != "#")   // Skip column notes
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", fOp, fSize, fCond,
                            fHi, fTrap, fa, fb, fc, fExcen, fo, fExc);
                if (n == 11)
                begin
                    v.instr = {fOp[4:0], fSize[1:0], fCond[2:0], fHi[0], fTrap[0]};
                    v.a = fa;
                    v.b = fb;
                    v.c = fc;
                    v.excen = fExcen[3:0];
                    v.expO = fo;
                    v.expExc = fault_t'(fExc[8:0]);
                    vectors.push_back(v);
                end
                else
                begin
                    otherErrors++;
                    $display("Vector file line could not be parsed: %s", line);
                end
            end
        end
        $fclose(fd);
    end
endtask

// Inputs held after the ld pulse until done
task automatic applyOp(input string name, input aluInstr_t i, input word_t va, input word_t vb,
                       input word_t vc, input faultEnable_t en);
    logic multi;
    int waited;
    int expWait;
    multi = i.op inside {opMul, opMulu, opDiv, opDivu};
    expWait = multi ? DBW : 1;   // Multi-cycle units finish DBW cycles after start
    @(posedge clk);
    instr <= i;
    a <= va;
    b <= vb;
    c <= vc;
    excen <= en;
    ld <= 1'b1;
    @(posedge clk);
    ld <= 1'b0;
    @(negedge clk);
    checkLevel($sformatf("%s idle after load", name), !multi, idle);
    waited = 1;
    while (done !== 1'b1)
    begin
        @(negedge clk);
        waited++;
    end
    checkLevel($sformatf("%s idle at done", name), 1'b1, idle);
    checks++;
    if (waited != expWait)
    begin
        otherErrors++;
        $display("error %s latency: expected %0d, actual %0d", name, expWait, waited);
    end
endtask

// ============================================================
// Test phases
// ============================================================

task automatic runVectors();
    vector_t cur;
    string name;
    foreach (vectors[i])
    begin
        cur = vectors[i];
        name = $sformatf("vector %0d %s", i, cur.instr.op.name());
        applyOp(name, cur.instr, cur.a, cur.b, cur.c, cur.excen);
        checkWord(name, cur.expO, o);
        checkFault(name, cur.expExc, exc);
    end
endtask

task automatic runRandom();
    aluInstr_t i;
    logic [31:0] sel;
    word_t va, vb, aMag, bMag, q, r, expO;
    dword_t full;
    logic sgn, aNeg, bNeg;
    string name;
    for (int k = 0; k < NumRandom; k++)
    begin
        sel = lcgNext();
        case (sel[31:30])
            2'd0:    i.op = opMul;
            2'd1:    i.op = opMulu;
            2'd2:    i.op = opDiv;
            default: i.op = opDivu;
        endcase
        i.size = lane64;
        i.cond = condEq;
        i.hiSel = sel[29];
        i.trap = 1'b0;
        va = randWord();
        vb = randWord();
        sgn = i.op inside {opMul, opDiv};
        if (i.op inside {opDiv, opDivu})
        begin
            vb = vb >> sel[5:0];   // Spread divisor sizes
            if (vb == '0)
                vb = 64'd1;
        end
        name = $sformatf("random %0d %s", k, i.op.name());
        applyOp(name, i, va, vb, '0, '0);
        if (i.op inside {opMul, opMulu})
        begin
            if (sgn)
                full = {{DBW{va[DBW-1]}}, va} * {{DBW{vb[DBW-1]}}, vb};
            else
                full = {{DBW{1'b0}}, va} * {{DBW{1'b0}}, vb};
            expO = i.hiSel ? full[2*DBW-1:DBW] : full[DBW-1:0];
        end
        else
        begin
            aNeg = sgn & va[DBW-1];
            bNeg = sgn & vb[DBW-1];
            aMag = aNeg ? -va : va;
            bMag = bNeg ? -vb : vb;
            q = aMag / bMag;
            r = aMag % bMag;
            if (aNeg ^ bNeg)
                q = -q;   // Truncate toward zero
            if (aNeg)
                r = -r;
            expO = i.hiSel ? r : q;
        end
        checkWord(name, expO, o);
        checkFault(name, faultNone, exc);
    end
endtask

// Divide by zero cut short, so the fault must not appear
task automatic runAbort();
    aluInstr_t i;
    i = '{op: opDiv, size: lane64, cond: condEq, hiSel: 1'b0, trap: 1'b0};
    @(posedge clk);
    instr <= i;
    a <= 64'd1;
    b <= '0;
    c <= '0;
    excen <= 4'hF;
    ld <= 1'b1;
    @(posedge clk);
    ld <= 1'b0;
    repeat (5) @(posedge clk);
    abort <= 1'b1;
    @(posedge clk);
    abort <= 1'b0;
    @(negedge clk);
    checkLevel("abort divide done", 1'b1, done);
    checkLevel("abort divide idle", 1'b1, idle);
    checkFault("abort divide", faultNone, exc);
endtask

initial
begin
    clk = 1'b0;
    rst = 1'b1;
    ld = 1'b0;
    abort = 1'b0;
    instr = '0;
    a = '0;
    b = '0;
    c = '0;
    excen = '0;
    checks = 0;
    wordErrors = 0;
    faultErrors = 0;
    levelErrors = 0;
    otherErrors = 0;
    loadVectors();
    if (!fileOk || vectors.size() == 0)
    begin
        $display("No vectors could be read from %s", VecFile);
        $display("Test failed");
        $finish;
    end
    else
    begin
        cycleLimit = (vectors.size() + NumRandom + 1) * (DBW + 4) + 200;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        runVectors();
        runRandom();
        runAbort();
        $display("Checks %0d, word errors %0d, fault errors %0d, level errors %0d, other errors %0d",
                 checks, wordErrors, faultErrors, levelErrors, otherErrors);
        if (wordErrors + faultErrors + levelErrors + otherErrors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
end

endmodule

/* testbench/ft64Alu_vectors.txt */
# op size cond hiSel trap a b c excen expectedO expectedExc, all hex
# op 00 add .. 10 cmovne, 11 mul, 12 mulu, 13 div, 14 divu; excen bits div mul sub add
00 0 2 0 0 80FF7F0102030405 0101010101010101 0 0 8100800203040506 000
00 1 2 0 0 FFFF00018000FFFE 0001FFFF80000003 0 0 0000000000000001 000
00 2 2 0 0 7FFFFFFF12345678 0000000100000008 0 0 8000000012345680 000
00 3 2 0 0 7FFFFFFFFFFFFFFF 1 0 F 8000000000000000 000
00 3 2 0 1 7FFFFFFFFFFFFFFF 1 0 1 8000000000000000 020
00 3 2 0 1 7FFFFFFFFFFFFFFF 1 0 E 8000000000000000 000
01 0 2 0 0 100 1 0 0 1FF 000
01 1 2 0 0 10000 1 0 0 1FFFF 000
01 2 2 0 0 100000000 1 0 0 1FFFFFFFF 000
01 3 2 0 1 8000000000000000 1 0 2 7FFFFFFFFFFFFFFF 020
01 3 2 0 1 5 3 0 2 2 000
02 0 2 0 0 80017F05FF000010 7F02800600FF0F10 0 0 80018005FFFF0010 000
03 0 2 0 0 80017F05FF000010 7F02800600FF0F10 0 0 7F027F0600000F10 000
02 1 2 0 0 8000000100020003 7FFFFFFF00030002 0 0 8000FFFF00020002 000
03 2 2 0 0 80000000FFFFFFFE 00000001FFFFFFFF 0 0 00000001FFFFFFFF 000
02 3 2 0 0 FFFFFFFFFFFFFFFF 1 0 0 FFFFFFFFFFFFFFFF 000
03 3 2 0 0 8000000000000000 7FFFFFFFFFFFFFFF 0 0 7FFFFFFFFFFFFFFF 000
04 0 2 0 0 FF AA00000000000001 0 0 FFFFFFFFFFFFFFFF 000
05 0 2 0 0 FF AA00000000000001 0 0 1 000
04 1 2 0 0 1234000000005555 9999000000005555 0 0 0 000
04 2 2 0 0 80000000 7FFFFFFF 0 0 FFFFFFFFFFFFFFFF 000
04 3 2 0 0 8000000000000000 7FFFFFFFFFFFFFFF 0 0 FFFFFFFFFFFFFFFF 000
05 3 2 0 0 8000000000000000 7FFFFFFFFFFFFFFF 0 0 1 000
06 0 4 0 0 80 1 0 0 1 000
07 0 4 0 0 80 1 0 0 0 000
06 1 5 0 0 7FFF 8000 0 0 1 000
07 1 7 0 0 7FFF 8000 0 0 0 000
06 2 6 0 0 FFFFFFFF 1 0 0 1 000
07 2 6 0 0 FFFFFFFF 1 0 0 0 000
07 2 5 0 0 100000001 2 0 0 0 000
06 3 3 0 0 5 5 0 0 0 000
07 3 2 0 0 FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0 0 1 000
08 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 F000F000F000F000 000
09 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 FFF0FFF0FFF0FFF0 000
0A 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 0FF00FF00FF00FF0 000
0B 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 0FFF0FFF0FFF0FFF 000
0C 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 000F000F000F000F 000
0D 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 F00FF00FF00FF00F 000
0E 3 2 0 0 F0F0F0F0F0F0F0F0 FF00FF00FF00FF00 123456789ABCDEF0 0 F230F670FAB0FEF0 000
0F 3 2 0 0 0 1111 2222 0 1111 000
0F 3 2 0 0 1 1111 2222 0 2222 000
10 3 2 0 0 1 1111 2222 0 1111 000
10 3 2 0 0 0 1111 2222 0 2222 000
11 3 2 0 0 FFFFFFFFFFFFFFFD 7 0 4 FFFFFFFFFFFFFFEB 000
11 3 2 1 0 FFFFFFFFFFFFFFFD 7 0 4 FFFFFFFFFFFFFFFF 000
12 3 2 1 0 FFFFFFFFFFFFFFFF 2 0 4 1 020
12 3 2 0 0 100000000 100000000 0 0 0 000
11 3 2 0 0 4000000000000000 4 0 4 0 020
11 3 2 0 0 4000000000000000 4 0 0 0 000
13 3 2 0 0 FFFFFFFFFFFFFFF9 2 0 8 FFFFFFFFFFFFFFFD 000
13 3 2 1 0 FFFFFFFFFFFFFFF9 2 0 8 FFFFFFFFFFFFFFFF 000
13 3 2 0 0 7 FFFFFFFFFFFFFFFE 0 8 FFFFFFFFFFFFFFFD 000
13 3 2 1 0 7 FFFFFFFFFFFFFFFE 0 8 1 000
14 3 2 0 0 64 7 0 8 E 000
14 3 2 1 0 64 7 0 8 2 000
13 3 2 0 0 1234 0 0 8 FFFFFFFFFFFFFFFF 021
13 3 2 1 0 1234 0 0 8 1234 021
13 3 2 1 0 FFFFFFFFFFFFFF00 0 0 8 FFFFFFFFFFFFFF00 021
14 3 2 0 0 FFFFFFFFFFFFFFF0 0 0 0 FFFFFFFFFFFFFFFF 000
14 3 2 1 0 FFFFFFFFFFFFFFF0 0 0 0 FFFFFFFFFFFFFFF0 000

/* ft64Alu.f */
verilog/ft64DataPkg.sv
verilog/ft64IsaPkg.sv
verilog/laneArith.sv
verilog/compareUnit.sv
verilog/seqMultiplier.sv
verilog/seqDivider.sv
verilog/faultDetect.sv
verilog/ft64Alu.sv
testbench/ft64Alu_checker.sv
testbench/ft64AluTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ft64Alu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f ft64Alu.f --top-module ft64AluTb -o simFt64Alu
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simFt64Alu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" <<< "$output"; then
    exit 0
else
    echo "Pass message not found in simulation output"
    exit 1
fi
